// ==== hdl/duckHuntPkg.sv ====
package duckHuntPkg;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////
	typedef logic signed [10:0] coordT;
	typedef logic [5:0] frameT;

	typedef enum logic [2:0] {HeadNW, HeadW, HeadNE, HeadE, HeadSW, HeadSE} headingT;
	typedef enum logic [1:0] {ColBlack, ColRed, ColPink} duckColorT; // Code 3 is black at spawn
	typedef enum logic [1:0] {PhaseFly, PhaseHit, PhaseFall} flightPhaseT;

	typedef struct packed {
		duckColorT colour;
		headingT heading;
		logic [9:0] startX;
		logic [1:0] repeats; // Extra flight cycles
	} spawnT;

	typedef struct packed {
		coordT x;
		coordT y;
	} duckPosT;

	typedef struct packed {
		duckPosT pos;
		frameT frame;
	} spriteT;

	////////////////////////////////////////
	// Field and motion constants
	////////////////////////////////////////
	localparam coordT FieldLeft = 11'sd0;
	localparam coordT FieldTop = 11'sd0;
	localparam coordT FieldRight = 11'sd576;
	localparam coordT FieldBottom = 11'sd236; // Also the spawn row
	localparam coordT FallLine = 11'sd300;
	localparam coordT BounceInset = 11'sd20;
	localparam coordT BounceInsetRight = 11'sd556;
	localparam coordT BounceInsetBottom = 11'sd216;
	localparam coordT StepLgX = 11'sd15;
	localparam coordT StepSmX = 11'sd12;
	localparam coordT StepLgY = 11'sd10;
	localparam coordT StepSmY = 11'sd2;
	localparam coordT FallStep = 11'sd10;

	localparam int HitHold = 16;
	localparam int RepeatBias = 3;
	localparam int MaxDucks = 10;
	localparam int SpriteCredits = 4;
	localparam int CreditW = 3;

	////////////////////////////////////////
	// Frame tables, [heading][colour]
	////////////////////////////////////////
	localparam frameT FlyFrameBase [0:5][0:2] = '{
		'{6'd11, 6'd31, 6'd51}, // NW
		'{6'd15, 6'd35, 6'd55}, // W
		'{6'd0, 6'd20, 6'd40}, // NE
		'{6'd4, 6'd24, 6'd44}, // E
		'{6'd11, 6'd31, 6'd51}, // SW uses NW art
		'{6'd0, 6'd20, 6'd40} // SE uses NE art
	};

	localparam frameT HitFrame [0:5][0:2] = '{
		'{6'd19, 6'd39, 6'd59},
		'{6'd19, 6'd39, 6'd59},
		'{6'd8, 6'd28, 6'd48},
		'{6'd8, 6'd28, 6'd48},
		'{6'd19, 6'd39, 6'd59},
		'{6'd8, 6'd28, 6'd48}
	};

	localparam frameT FallFrame [0:5][0:2] = '{
		'{6'd10, 6'd29, 6'd50},
		'{6'd10, 6'd29, 6'd50},
		'{6'd9, 6'd30, 6'd49},
		'{6'd9, 6'd30, 6'd49},
		'{6'd10, 6'd29, 6'd50},
		'{6'd9, 6'd30, 6'd49}
	};

	// Codes 6 and 7 from the random source fly east
	function automatic headingT legalHeading(input logic [2:0] code);
		return (code > 3'd5) ? HeadE : headingT'(code);
	endfunction

endpackage

// ==== hdl/duckFlightCtrl.sv ====
module duckFlightCtrl (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic Run,
	input  logic shot,
	input  logic creditAvail,
	input  logic atEdge,
	input  logic belowFallLine,
	input  logic [1:0] repeats,
	output logic step,
	output logic loadSpawn,
	output logic fly,
	output logic bounce,
	output logic reHead,
	output logic fall,
	output logic flyStart,
	output duckHuntPkg::flightPhaseT phase,
	output logic [duckHuntPkg::MaxDucks-1:0] duckKilled
);
	import duckHuntPkg::*;

	localparam int HitW = $clog2(HitHold);
	localparam int NumW = $clog2(MaxDucks);

	typedef enum logic [3:0] {
		StIdle, StSpawn, StSpawnFrame, StFly1, StFly2, StFly3, StFly4,
		StBounce1, StBounce2, StHit, StFall
	} flightStateT;

	flightStateT state;
	flightStateT nextState;
	logic [2:0] flyCnt; // Completed flight cycles
	logic [2:0] cycleTarget;
	logic [HitW-1:0] hitCnt;
	logic [NumW-1:0] duckNum;
	logic flying;
	logic lastCycle;
	logic hitDone;

	assign step = creditAvail && (state != StIdle); // One record per step
	assign flying = state inside {StFly1, StFly2, StFly3, StFly4};
	assign lastCycle = (flyCnt == cycleTarget - 3'd1);
	assign hitDone = (hitCnt == HitW'(HitHold - 1));

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////
	assign loadSpawn = (state == StSpawn);
	assign fly = flying && !shot; // Hit duck freezes in place
	assign bounce = (state == StBounce1);
	assign reHead = (state == StFly4) && !shot && !atEdge && lastCycle;
	assign fall = (state == StFall) && !belowFallLine;
	assign flyStart = (state == StSpawnFrame) || (state == StBounce2);

	always_comb
	begin
		case (state)
			StHit: phase = PhaseHit;
			StFall: phase = PhaseFall;
			default: phase = PhaseFly;
		endcase
	end

	always_comb
	begin
		nextState = state;
		case (state)
			StIdle: if (Run) nextState = StSpawn;
			StSpawn: nextState = StSpawnFrame;
			StSpawnFrame: nextState = StFly1;
			StFly1, StFly2, StFly3, StFly4:
				if (shot)
					nextState = StHit;
				else if (atEdge)
					nextState = StBounce1;
				else if (state == StFly4)
					nextState = lastCycle ? StSpawnFrame : StFly1; // New heading after last cycle
				else
					nextState = flightStateT'(state + 4'd1);
			StBounce1: nextState = StBounce2;
			StBounce2: nextState = StFly1;
			StHit: if (hitDone) nextState = StFall;
			StFall: if (belowFallLine) nextState = StSpawn; // Gone, next duck
			default: nextState = StIdle;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= StIdle;
			flyCnt <= '0;
			cycleTarget <= 3'(RepeatBias);
			hitCnt <= '0;
			duckNum <= '0;
			duckKilled <= '0;
		end
		else
		begin
			if (state == StIdle || step) // Idle leaves without a step
				state <= nextState;
			if (step)
			begin
				if (loadSpawn || reHead)
					cycleTarget <= {1'b0, repeats} + 3'(RepeatBias);
				if (loadSpawn || reHead || (flying && nextState == StBounce1))
					flyCnt <= '0; // A bounce restarts the count
				else if (state == StFly4 && nextState == StFly1)
					flyCnt <= flyCnt + 3'd1;
				if (state == StHit)
					hitCnt <= hitDone ? '0 : hitCnt + 1'b1;
				if (state == StFall && belowFallLine)
				begin
					duckKilled[duckNum] <= 1'b1;
					duckNum <= (duckNum == NumW'(MaxDucks - 1)) ? '0 : duckNum + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/duckMotion.sv ====
module duckMotion (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic step,
	input  logic loadSpawn,
	input  logic fly,
	input  logic bounce,
	input  logic reHead,
	input  logic fall,
	input  duckHuntPkg::spawnT spawn,
	output duckHuntPkg::duckPosT pos,
	output duckHuntPkg::headingT heading,
	output duckHuntPkg::duckColorT colour,
	output logic atEdge,
	output logic belowFallLine
);
	import duckHuntPkg::*;

	coordT dx;
	coordT dy;
	coordT xSum;
	coordT ySum;
	duckPosT flyPos;
	duckPosT bouncePos;
	headingT bounceHeading;
	logic atLeft;
	logic atTop;
	logic atRight;
	logic atBottom;

	assign atLeft = (pos.x <= FieldLeft);
	assign atTop = (pos.y <= FieldTop);
	assign atRight = (pos.x >= FieldRight);
	assign atBottom = (pos.y >= FieldBottom);
	assign atEdge = atLeft || atTop || atRight || atBottom;
	assign belowFallLine = (pos.y > FallLine);

	////////////////////////////////////////
	// Step vector and clamping
	////////////////////////////////////////
	always_comb
	begin
		case (heading)
			HeadNW: begin dx = -StepSmX; dy = -StepLgY; end
			HeadW: begin dx = -StepLgX; dy = -StepSmY; end
			HeadNE: begin dx = StepSmX; dy = -StepLgY; end
			HeadE: begin dx = StepLgX; dy = -StepSmY; end
			HeadSW: begin dx = -StepSmX; dy = StepLgY; end
			HeadSE: begin dx = StepSmX; dy = StepLgY; end
			default: begin dx = '0; dy = '0; end
		endcase
		xSum = pos.x + dx;
		ySum = pos.y + dy;
		flyPos.x = (xSum < FieldLeft) ? FieldLeft : xSum; // East side left open
		if (ySum < FieldTop)
			flyPos.y = FieldTop;
		else if (ySum > FieldBottom)
			flyPos.y = FieldBottom;
		else
			flyPos.y = ySum;
	end

	// Reflection, the later matching edge wins
	always_comb
	begin
		bounceHeading = heading;
		bouncePos = pos;
		case (heading)
			HeadNW, HeadW:
			begin
				if (atTop) begin bounceHeading = HeadSW; bouncePos.y = FieldTop + BounceInset; end
				if (atLeft)
				begin
					bounceHeading = (heading == HeadNW) ? HeadNE : HeadE;
					bouncePos.x = FieldLeft + BounceInset;
				end
			end
			HeadNE, HeadE:
			begin
				if (atRight)
				begin
					bounceHeading = (heading == HeadNE) ? HeadNW : HeadW;
					bouncePos.x = BounceInsetRight;
				end
				if (atTop) begin bounceHeading = HeadSE; bouncePos.y = FieldTop + BounceInset; end
			end
			HeadSW:
			begin
				if (atBottom) begin bounceHeading = HeadNW; bouncePos.y = BounceInsetBottom; end
				if (atLeft) begin bounceHeading = HeadSE; bouncePos.x = FieldLeft + BounceInset; end
			end
			HeadSE:
			begin
				if (atRight) begin bounceHeading = HeadSW; bouncePos.x = BounceInsetRight; end
				if (atBottom) begin bounceHeading = HeadNE; bouncePos.y = BounceInsetBottom; end
			end
			default: ;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			pos <= '0;
			heading <= HeadNW;
			colour <= ColBlack;
		end
		else if (step)
		begin
			if (loadSpawn)
			begin
				pos.x <= coordT'({1'b0, spawn.startX});
				pos.y <= FieldBottom; // Rise from the grass line
				heading <= legalHeading(spawn.heading);
				colour <= (spawn.colour > ColPink) ? ColBlack : spawn.colour;
			end
			if (fly)
				pos <= flyPos;
			if (reHead)
				heading <= legalHeading(spawn.heading);
			if (bounce)
			begin
				pos <= bouncePos;
				heading <= bounceHeading;
			end
			if (fall)
				pos.y <= pos.y + FallStep;
		end
	end

endmodule

// ==== hdl/duckSpriteSel.sv ====
module duckSpriteSel (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic step,
	input  logic flyStart,
	input  duckHuntPkg::flightPhaseT phase,
	input  duckHuntPkg::headingT heading,
	input  duckHuntPkg::duckColorT colour,
	output duckHuntPkg::frameT frame
);
	import duckHuntPkg::*;

	frameT flyBase; // First wing frame of the heading
	logic [1:0] wingCnt; // Four wing frames per cycle

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			flyBase <= '0;
			wingCnt <= '0;
		end
		else if (step)
		begin
			if (flyStart)
			begin
				flyBase <= FlyFrameBase[heading][colour];
				wingCnt <= '0;
			end
			else if (phase == PhaseFly)
				wingCnt <= wingCnt + 2'd1; // Wraps back to the base frame
		end
	end

	////////////////////////////////////////
	// Frame select
	////////////////////////////////////////
	always_comb
	begin
		case (phase)
			PhaseHit: frame = HitFrame[heading][colour];
			PhaseFall: frame = FallFrame[heading][colour];
			default: frame = flyBase + frameT'(wingCnt);
		endcase
	end

endmodule

// ==== hdl/spriteCreditTx.sv ====
module spriteCreditTx (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic step,
	input  logic creditReturn,
	input  duckHuntPkg::spriteT record,
	output logic creditAvail,
	output duckHuntPkg::spriteT sprite,
	output logic spriteValid
);
	import duckHuntPkg::*;

	logic [CreditW-1:0] credits; // Free renderer slots

	assign creditAvail = (credits != '0);

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			credits <= CreditW'(SpriteCredits);
			spriteValid <= 1'b0;
		end
		else
		begin
			spriteValid <= step;
			case ({step, creditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01:
					if (credits < CreditW'(SpriteCredits)) // Extra returns are dropped
						credits <= credits + 1'b1;
				default: ; // Consume and return cancel
			endcase
		end
	end

	// Record of the state being left
	always_ff @(posedge ANIM_Clk)
	begin
		if (step)
			sprite <= record;
	end

endmodule

// ==== hdl/duckHuntAnim.sv ====
module duckHuntAnim (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic Run,
	input  logic shot,
	input  duckHuntPkg::spawnT spawn,
	input  logic creditReturn,
	output duckHuntPkg::spriteT sprite,
	output logic spriteValid,
	output logic [duckHuntPkg::MaxDucks-1:0] duckKilled
);
	import duckHuntPkg::*;

	logic step;
	logic loadSpawn;
	logic fly;
	logic bounce;
	logic reHead;
	logic fall;
	logic flyStart;
	logic atEdge;
	logic belowFallLine;
	logic creditAvail;
	flightPhaseT phase;
	duckPosT pos;
	headingT heading;
	duckColorT colour;
	frameT frame;
	spriteT record;

	assign record = '{pos: pos, frame: frame};

	////////////////////////////////////////
	// Flight control and motion
	////////////////////////////////////////
	duckFlightCtrl duckFlightCtrl_inst (
		.ANIM_Clk(ANIM_Clk), .Reset(Reset), .Run(Run), .shot(shot),
		.creditAvail(creditAvail), .atEdge(atEdge), .belowFallLine(belowFallLine),
		.repeats(spawn.repeats), .step(step), .loadSpawn(loadSpawn), .fly(fly),
		.bounce(bounce), .reHead(reHead), .fall(fall), .flyStart(flyStart),
		.phase(phase), .duckKilled(duckKilled)
	);

	duckMotion duckMotion_inst (
		.ANIM_Clk(ANIM_Clk), .Reset(Reset), .step(step), .loadSpawn(loadSpawn),
		.fly(fly), .bounce(bounce), .reHead(reHead), .fall(fall), .spawn(spawn),
		.pos(pos), .heading(heading), .colour(colour), .atEdge(atEdge),
		.belowFallLine(belowFallLine)
	);

	////////////////////////////////////////
	// Sprite frame and renderer channel
	////////////////////////////////////////
	duckSpriteSel duckSpriteSel_inst (
		.ANIM_Clk(ANIM_Clk), .Reset(Reset), .step(step), .flyStart(flyStart),
		.phase(phase), .heading(heading), .colour(colour), .frame(frame)
	);

	spriteCreditTx spriteCreditTx_inst (
		.ANIM_Clk(ANIM_Clk), .Reset(Reset), .step(step), .creditReturn(creditReturn),
		.record(record), .creditAvail(creditAvail), .sprite(sprite),
		.spriteValid(spriteValid)
	);

endmodule

// ==== bench/duckHuntAnim_props.sv ====
module duckHuntAnim_props (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic spriteValid,
	input  logic creditReturn,
	input  logic [duckHuntPkg::MaxDucks-1:0] duckKilled
);
	timeunit 1ns;
	timeprecision 1ps;
	import duckHuntPkg::*;

	int outstanding; // Records held by the renderer

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(spriteValid) - int'(creditReturn && outstanding > 0);
	end

	assert property (@(posedge ANIM_Clk) disable iff (Reset) outstanding <= SpriteCredits)
		else $error("More sprite records in flight than credits");

	assert property (@(posedge ANIM_Clk) Reset |-> !spriteValid)
		else $error("spriteValid high during reset");

	assert property (@(posedge ANIM_Clk) disable iff (Reset)
		($past(duckKilled) & ~duckKilled) == '0)
		else $error("Kill tally bit cleared");

endmodule

bind duckHuntAnim duckHuntAnim_props duckHuntAnim_props_inst (
	.ANIM_Clk(ANIM_Clk), .Reset(Reset), .spriteValid(spriteValid),
	.creditReturn(creditReturn), .duckKilled(duckKilled)
);

// ==== bench/duckHuntAnim_tb.sv ====
module duckHuntAnim_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import duckHuntPkg::*;

	logic ANIM_Clk;
	logic Reset;
	logic Run;
	logic shot;
	spawnT spawn;
	logic creditReturn;
	spriteT sprite;
	logic spriteValid;
	logic [MaxDucks-1:0] duckKilled;
	logic autoReturn; // Renderer frees each record at once
	logic manualReturn;
	int seed = 17;
	int mismatches = 0;
	int failures = 0;

	duckHuntAnim duckHuntAnim_inst (
		.ANIM_Clk(ANIM_Clk), .Reset(Reset), .Run(Run), .shot(shot), .spawn(spawn),
		.creditReturn(creditReturn), .sprite(sprite), .spriteValid(spriteValid),
		.duckKilled(duckKilled)
	);

	always #20 ANIM_Clk = ~ANIM_Clk;

	// Renderer credit model
	always @(posedge ANIM_Clk)
	begin
		#1 creditReturn = (autoReturn && spriteValid) || manualReturn;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic duckPosT stepPos(input duckPosT p, input headingT h);
		coordT dx;
		coordT dy;
		duckPosT n;
		dx = (h inside {HeadW, HeadE}) ? StepLgX : StepSmX;
		dy = (h inside {HeadW, HeadE}) ? StepSmY : StepLgY;
		if (h inside {HeadNW, HeadW, HeadSW})
			dx = -dx;
		if (!(h inside {HeadSW, HeadSE}))
			dy = -dy;
		n.x = (p.x + dx < FieldLeft) ? FieldLeft : p.x + dx; // No clamp on the east side
		n.y = p.y + dy;
		if (n.y < FieldTop)
			n.y = FieldTop;
		else if (n.y > FieldBottom)
			n.y = FieldBottom;
		return n;
	endfunction

	function automatic spriteT makeSprite(input duckPosT p, input int f);
		return '{pos: p, frame: frameT'(f)};
	endfunction

	////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////
	task automatic checkSprite(input spriteT got, input spriteT exp, input bit withFrame,
		input string what);
		if (got.pos !== exp.pos || (withFrame && got.frame !== exp.frame))
		begin
			mismatches++;
			$display("Mismatch at %0t: %s got (%0d,%0d) frame %0d, expected (%0d,%0d) frame %0d",
				$time, what, got.pos.x, got.pos.y, got.frame, exp.pos.x, exp.pos.y, exp.frame);
		end
	endtask

	task automatic checkKilled(input logic [MaxDucks-1:0] got, input logic [MaxDucks-1:0] exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("Mismatch at %0t: kill tally %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		if (got != exp)
		begin
			mismatches++;
			$display("Mismatch at %0t: %s count %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic nextRecord(output spriteT r);
		int n;
		r = '0;
		for (n = 0; n < 60; n++)
		begin
			@(negedge ANIM_Clk);
			if (spriteValid)
			begin
				r = sprite;
				return;
			end
		end
		failures++;
		$display("No sprite record arrived within 60 cycles at %0t", $time);
	endtask

	task automatic countRecords(input int cycles, output int cnt);
		cnt = 0;
		repeat (cycles)
		begin
			@(negedge ANIM_Clk);
			if (spriteValid)
				cnt++;
		end
	endtask

	task automatic applyReset;
		@(posedge ANIM_Clk);
		#2 Reset = 1'b1;
		Run = 1'b0;
		shot = 1'b0;
		autoReturn = 1'b0;
		manualReturn = 1'b0;
		repeat (2) @(posedge ANIM_Clk);
		#2 Reset = 1'b0;
	endtask

	task automatic startRun(input spawnT s, input logic hit, input logic auto);
		@(posedge ANIM_Clk);
		#2 spawn = s;
		shot = hit;
		autoReturn = auto;
		Run = 1'b1;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic testIdle;
		int cnt;
		applyReset();
		countRecords(20, cnt);
		checkCount(cnt, 0, "idle record");
		checkKilled(duckKilled, '0);
	endtask

	task automatic testBackPressure;
		int cnt;
		applyReset();
		startRun('{colour: ColRed, heading: HeadNW, startX: 10'd300, repeats: 2'd0}, 1'b0, 1'b0);
		countRecords(30, cnt);
		checkCount(cnt, SpriteCredits, "stalled record");
		@(posedge ANIM_Clk);
		#2 manualReturn = 1'b1;
		@(posedge ANIM_Clk);
		#2 manualReturn = 1'b0;
		countRecords(20, cnt);
		checkCount(cnt, 1, "released record");
	endtask

	// Covers spawn and flight (NW) or a bottom bounce (SE)
	task automatic testFlight(input headingT h, input duckColorT c, input headingT after);
		spriteT r;
		duckPosT p;
		int base;
		int k;
		p.x = coordT'(100 + ($random(seed) & 127));
		p.y = FieldBottom;
		startRun('{colour: c, heading: h, startX: 10'(p.x), repeats: 2'd0}, 1'b0, 1'b1);
		base = FlyFrameBase[h][(c == 2'd3) ? 0 : c];
		nextRecord(r); // Spawn step shows the previous duck
		nextRecord(r);
		checkSprite(r, makeSprite(p, 0), 1'b0, "spawn position");
		nextRecord(r);
		checkSprite(r, makeSprite(p, base), 1'b1, "first flight");
		p = stepPos(p, h);
		nextRecord(r);
		checkSprite(r, makeSprite(p, base + 1), 1'b1, "bounce entry");
		if (h == HeadSE)
			p.y = BounceInsetBottom;
		nextRecord(r);
		checkSprite(r, makeSprite(p, base + 2), 1'b1, "bounce exit");
		base = FlyFrameBase[after][(c == 2'd3) ? 0 : c];
		for (k = 0; k < 3; k++)
		begin
			nextRecord(r);
			checkSprite(r, makeSprite(p, base + k), 1'b1, "flight step");
			p = stepPos(p, after);
		end
	endtask

	task automatic testHitFall;
		spriteT r;
		duckPosT p;
		int c;
		int k;
		logic gone;
		c = $random(seed) & 3;
		p.x = coordT'(200 + ($random(seed) & 127));
		p.y = FieldBottom;
		startRun('{colour: duckColorT'(c), heading: HeadNW, startX: 10'(p.x), repeats: 2'd1},
			1'b1, 1'b1);
		c = (c == 3) ? 0 : c;
		nextRecord(r);
		nextRecord(r);
		nextRecord(r);
		checkSprite(r, makeSprite(p, FlyFrameBase[HeadNW][c]), 1'b1, "flight before hit");
		for (k = 0; k < HitHold; k++)
		begin
			nextRecord(r);
			checkSprite(r, makeSprite(p, HitFrame[HeadNW][c]), 1'b1, "hit hold");
		end
		gone = 1'b0;
		for (k = 0; k < 12 && !gone; k++)
		begin
			nextRecord(r);
			checkSprite(r, makeSprite(p, FallFrame[HeadNW][c]), 1'b1, "fall step");
			if (p.y > FallLine)
				gone = 1'b1; // Last fall record, below the line
			else
				p.y = p.y + FallStep;
		end
		checkKilled(duckKilled, MaxDucks'(1));
		nextRecord(r); // Spawn step still shows the fallen duck
		checkSprite(r, makeSprite(p, 0), 1'b0, "spawn step");
		p.y = FieldBottom;
		nextRecord(r);
		checkSprite(r, makeSprite(p, 0), 1'b0, "respawn position");
	endtask

	initial
	begin
		ANIM_Clk = 1'b0;
		Reset = 1'b1;
		Run = 1'b0;
		shot = 1'b0;
		spawn = '0;
		creditReturn = 1'b0;
		autoReturn = 1'b0;
		manualReturn = 1'b0;
		testIdle();
		testBackPressure();
		applyReset();
		testFlight(HeadNW, duckColorT'(2'd3), HeadNW);
		applyReset();
		testFlight(HeadSE, ColBlack, HeadNE);
		applyReset();
		testHitFall();
		$display("Closing: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
hdl/duckHuntPkg.sv
hdl/duckFlightCtrl.sv
hdl/duckMotion.sv
hdl/duckSpriteSel.sv
hdl/spriteCreditTx.sv
hdl/duckHuntAnim.sv
bench/duckHuntAnim_props.sv
bench/duckHuntAnim_tb.sv

// ==== Bender.yml ====
package:
  name: duck_hunt_anim

sources:
  - hdl/duckHuntPkg.sv
  - hdl/duckFlightCtrl.sv
  - hdl/duckMotion.sv
  - hdl/duckSpriteSel.sv
  - hdl/spriteCreditTx.sv
  - hdl/duckHuntAnim.sv
  - target: test
    files:
      - bench/duckHuntAnim_props.sv
      - bench/duckHuntAnim_tb.sv
